/* verification/circuito_principal_chk.sv */
`timescale 1ns/1ns

module circuito_principal_chk (
    input logic                  clock,
    input logic                  rst,
    input logic                  ganhou,
    input logic                  perdeu,
    input logic                  vez_jogador,
    input music_game_pkg::leds_t leds
);
    int assertion_failures = 0;

    // Win and loss are exclusive end states
    fim_exclusivo: assert property (
        @(posedge clock) disable iff (rst) !(ganhou && perdeu)
    ) else begin
        assertion_failures++;
        $error("ganhou and perdeu are high together");
    end

    leds_one_hot: assert property (
        @(posedge clock) disable iff (rst) $onehot0(leds)
    ) else begin
        assertion_failures++;
        $error("leds has more than one bit set: 0x%h", leds);
    end

    // Dark during the player's turn
    leds_apagados: assert property (
        @(posedge clock) disable iff (rst) vez_jogador |-> (leds == '0)
    ) else begin
        assertion_failures++;
        $error("leds lit while vez_jogador is high: 0x%h", leds);
    end

endmodule

bind circuito_principal circuito_principal_chk chk (
    .clock       ( clock       ),
    .rst         ( rst         ),
    .ganhou      ( ganhou      ),
    .perdeu      ( perdeu      ),
    .vez_jogador ( vez_jogador ),
    .leds        ( leds        )
);

/* verification/circuito_principal_stim.txt */
# action (0 start, 1 play, 2 retry, 3 wait-timeout), pitch in hex, beats held, outcome
# outcome 0 continue, 1 win, 2 lose; pitch and beats are 0 unless the action is play
0 0 0 0
1 5 1 0
1 5 1 0
1 5 1 0
1 4 1 2
2 0 0 0
1 5 2 2
2 0 0 0
1 5 1 0
1 5 1 0
1 7 1 2
2 0 0 0
3 0 0 2
2 0 0 0
1 5 1 0
1 5 1 0
1 7 2 0
1 5 1 0
1 5 1 0
1 7 2 0
1 5 2 0
1 5 1 0
1 5 1 0
1 7 2 0
1 5 2 0
1 a 2 0
1 5 1 0
1 5 1 0
1 7 2 0
1 5 2 0
1 a 2 0
1 9 4 1
0 0 0 0
1 5 1 0
1 4 1 2
0 0 0 0
1 5 1 0

/* verification/circuito_principal_tb.sv */
`timescale 1ns/1ns

module circuito_principal_tb;
    import music_game_pkg::*;

    localparam int          CLOCK_FREQ   = 8;
    localparam int          BEAT         = CLOCK_FREQ / 2;
    localparam int          BUZZER_HALF  = 4;
    localparam int          RESET_CYCLES = 8;
    localparam logic [31:0] SEED         = 32'hba22_3c5e;
    localparam string       STIM_FILE    = "verification/circuito_principal_stim.txt";

    localparam int ACT_START    = 0;
    localparam int ACT_PLAY     = 1;
    localparam int ACT_RETRY    = 2;
    localparam int ACT_TIMEOUT  = 3;
    localparam int RES_CONTINUE = 0;
    localparam int RES_WIN      = 1;
    localparam int RES_LOSE     = 2;
    localparam int WAIT_LEDS    = 0;
    localparam int WAIT_VEZ     = 1;

    logic       clock = 1'b0;
    logic       rst;
    logic       iniciar;
    logic       tentar_dnv;
    nota_t      botoes_encoded;
    logic       ganhou;
    logic       perdeu;
    logic       vez_jogador;
    leds_t      leds;
    logic       pulso_buzzer;
    logic [6:0] db_nota;
    logic [6:0] db_rodada;

    int        acoes[$];
    nota_t     notas[$];
    int        batidas[$];
    int        resultados[$];
    int        value_errors  = 0;
    int        timing_errors = 0;
    int        cycles        = 0;
    int        cycle_limit   = 0;
    endereco_t rodada;
    int        nota_idx;

    circuito_principal #(.CLOCK_FREQ(CLOCK_FREQ)) dut (
        .clock          ( clock          ),
        .rst            ( rst            ),
        .iniciar        ( iniciar        ),
        .tentar_dnv     ( tentar_dnv     ),
        .botoes_encoded ( botoes_encoded ),
        .ganhou         ( ganhou         ),
        .perdeu         ( perdeu         ),
        .vez_jogador    ( vez_jogador    ),
        .leds           ( leds           ),
        .pulso_buzzer   ( pulso_buzzer   ),
        .db_nota        ( db_nota        ),
        .db_rodada      ( db_rodada      )
    );

    always #2 clock = ~clock;

    function automatic int total_errors();
        return value_errors + timing_errors + dut.chk.assertion_failures;
    endfunction

    task automatic print_summary();
        $display("Summary: %0d value errors, %0d timing errors, %0d assertion failures",
                 value_errors, timing_errors, dut.chk.assertion_failures);
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles before the stimulus was done", cycles);
            print_summary();
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_leds(input string name, input leds_t expected, input leds_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    task automatic check_nota(input string name, input nota_t expected, input nota_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    task automatic check_rodada(input string name, input endereco_t expected,
                                input endereco_t actual);
        if (actual !== expected) begin
            $display("ERR %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
            value_errors++;
        end
    endtask

    // Active-low gfedcba pattern back to its hex digit
    function automatic nota_t digit_of_segments(input logic [6:0] seg);
        case (seg)
            7'b1000000: return 4'h0;
            7'b1111001: return 4'h1;
            7'b0100100: return 4'h2;
            7'b0110000: return 4'h3;
            7'b0011001: return 4'h4;
            7'b0010010: return 4'h5;
            7'b0000010: return 4'h6;
            7'b1111000: return 4'h7;
            7'b0000000: return 4'h8;
            7'b0010000: return 4'h9;
            7'b0001000: return 4'hA;
            7'b0000011: return 4'hB;
            7'b1000110: return 4'hC;
            7'b0100001: return 4'hD;
            7'b0000110: return 4'hE;
            7'b0001110: return 4'hF;
            default:    return 4'hx;
        endcase
    endfunction

    function automatic bit condition_met(input int cond);
        case (cond)
            WAIT_LEDS: return leds != '0;
            WAIT_VEZ:  return vez_jogador === 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    task automatic wait_until(input int cond, input string what, input int limit);
        int n;
        n = 0;
        while (!condition_met(cond) && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (!condition_met(cond)) begin
            $display("Waited %0d cycles for %s and it never came", limit, what);
            timing_errors++;
        end
    endtask

    task automatic press_start();
        iniciar = 1'b1;
        @(negedge clock);
        iniciar = 1'b0;
    endtask

    task automatic press_retry();
        tentar_dnv = 1'b1;
        @(negedge clock);
        tentar_dnv = 1'b0;
        check_flag("perdeu", 1'b0, perdeu);
    endtask

    // Notes 0 to r, each lit for its length and then a dark gap
    task automatic check_playback(input endereco_t r);
        leds_t expected;
        int    len;
        int    i;
        int    c;
        wait_until(WAIT_LEDS, "the first played note", 3 * BEAT);
        check_rodada("db_rodada", r, digit_of_segments(db_rodada));
        for (i = 0; i <= r; i++) begin
            expected = leds_t'(1) << (SONG_NOTAS[i] - 1);
            len      = SONG_TEMPOS[i] * BEAT;
            for (c = 0; c < len; c++) begin
                check_leds("leds", expected, leds);
                check_flag("pulso_buzzer", ((c / BUZZER_HALF) % 2) ? 1'b1 : 1'b0, pulso_buzzer);
                check_flag("vez_jogador", 1'b0, vez_jogador);
                @(negedge clock);
            end
            for (c = 0; c < GAP_BEATS * BEAT; c++) begin
                check_leds("leds", '0, leds);
                check_flag("pulso_buzzer", 1'b0, pulso_buzzer);
                @(negedge clock);
            end
        end
        check_flag("vez_jogador", 1'b1, vez_jogador);
    endtask

    task automatic check_outcome(input int outcome);
        check_flag("ganhou", (outcome == RES_WIN) ? 1'b1 : 1'b0, ganhou);
        check_flag("perdeu", (outcome == RES_LOSE) ? 1'b1 : 1'b0, perdeu);
    endtask

    task automatic play_note(input nota_t pitch, input int beats, input int outcome);
        int gap;
        int c;
        wait_until(WAIT_VEZ, "vez_jogador", 2 * BEAT);
        gap = $urandom % 4;
        repeat (gap) @(negedge clock);
        botoes_encoded = pitch;
        for (c = 0; c < beats * BEAT; c++) begin
            @(negedge clock);
            check_flag("vez_jogador", 1'b1, vez_jogador);
        end
        botoes_encoded = '0;
        // Decision lands two cycles after release
        repeat (2) @(negedge clock);
        check_outcome(outcome);
        if (outcome == RES_WIN) begin
            check_nota("db_nota", pitch, digit_of_segments(db_nota));
        end
    endtask

    task automatic wait_timeout();
        int n;
        wait_until(WAIT_VEZ, "vez_jogador", 2 * BEAT);
        n = 0;
        while (perdeu !== 1'b1 && n < (TIMEOUT_BEATS + 1) * BEAT) begin
            @(negedge clock);
            n++;
        end
        if (perdeu !== 1'b1) begin
            $display("perdeu still low %0d cycles into an idle player turn", n);
            timing_errors++;
        end else if (n < TIMEOUT_BEATS * BEAT) begin
            $display("perdeu came after only %0d cycles of an idle player turn", n);
            timing_errors++;
        end
        check_flag("ganhou", 1'b0, ganhou);
    endtask

    task automatic load_stimulus(output bit ok);
        int                 fd;
        int                 a;
        int                 b;
        int                 o;
        nota_t              p;
        logic [8*160-1:0]   line;
        ok = 1'b0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            // Two column description lines
            void'($fgets(line, fd));
            void'($fgets(line, fd));
            while ($fscanf(fd, "%d %h %d %d\n", a, p, b, o) == 4) begin
                acoes.push_back(a);
                notas.push_back(p);
                batidas.push_back(b);
                resultados.push_back(o);
            end
            $fclose(fd);
            ok = (acoes.size() > 0);
        end
    endtask

    // Any line can start at most one full playback
    function automatic int cycle_budget();
        int playback;
        int beats;
        int k;
        playback = 0;
        for (k = 0; k < NUM_NOTAS; k++) begin
            playback = playback + SONG_TEMPOS[k] + GAP_BEATS;
        end
        beats = 0;
        for (k = 0; k < acoes.size(); k++) begin
            beats = beats + batidas[k] + playback + 1;
            if (acoes[k] == ACT_TIMEOUT) begin
                beats = beats + TIMEOUT_BEATS;
            end
        end
        return beats * BEAT * 2 + RESET_CYCLES;
    endfunction

    task automatic run_all();
        int k;
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;
        @(negedge clock);
        check_flag("ganhou", 1'b0, ganhou);
        check_flag("perdeu", 1'b0, perdeu);
        check_flag("vez_jogador", 1'b0, vez_jogador);
        check_flag("pulso_buzzer", 1'b0, pulso_buzzer);
        check_leds("leds", '0, leds);
        for (k = 0; k < acoes.size(); k++) begin
            case (acoes[k])
                ACT_START: begin
                    press_start();
                    rodada   = '0;
                    nota_idx = 0;
                    check_playback(rodada);
                end
                ACT_RETRY: begin
                    press_retry();
                    nota_idx = 0;
                    check_playback(rodada);
                end
                ACT_TIMEOUT: begin
                    wait_timeout();
                end
                ACT_PLAY: begin
                    play_note(notas[k], batidas[k], resultados[k]);
                    if (resultados[k] == RES_CONTINUE) begin
                        if (nota_idx == rodada) begin
                            rodada   = rodada + 1'b1;
                            nota_idx = 0;
                            check_playback(rodada);
                        end else begin
                            nota_idx++;
                            @(negedge clock);
                        end
                    end
                end
                default: begin
                    $display("Unknown action code %0d on stimulus entry %0d", acoes[k], k);
                    timing_errors++;
                end
            endcase
        end
    endtask

    initial begin
        bit loaded;
        rst            = 1'b1;
        iniciar        = 1'b0;
        tentar_dnv     = 1'b0;
        botoes_encoded = '0;
        rodada         = '0;
        nota_idx       = 0;
        void'($urandom(SEED));
        load_stimulus(loaded);
        if (!loaded) begin
            $display("Could not read any entry from %s", STIM_FILE);
            print_summary();
            $display("Testbench failed");
            $finish;
        end else begin
            cycle_limit = cycle_budget();
            run_all();
            print_summary();
            if (total_errors() == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

/* verilog/circuito_principal.sv */
`timescale 1ns/1ns

module circuito_principal #(
    parameter int CLOCK_FREQ = 50000000
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  iniciar,
    input  logic                  tentar_dnv,
    input  music_game_pkg::nota_t botoes_encoded,
    output logic                  ganhou,
    output logic                  perdeu,
    output logic                  vez_jogador,
    output music_game_pkg::leds_t leds,
    output logic                  pulso_buzzer,
    output logic [6:0]            db_nota,
    output logic [6:0]            db_rodada
);
    import music_game_pkg::*;

    // Control strobes
    logic zeraE, contaE, zeraR, contaR, zeraT, contaT;
    logic registraJ, ativa_leds;

    // Conditions
    logic fimNota, fimPausa, enderecoIgualRodada, fim_musica;
    logic nota_feita, fimTempo, nota_correta, tempo_correto;

    nota_t     s_db_nota;
    endereco_t s_db_rodada;

    fluxo_dados #(.CLOCK_FREQ(CLOCK_FREQ)) fluxo_dados (
        .clock               ( clock               ),
        .rst                 ( rst                 ),
        .botoes_encoded      ( botoes_encoded      ),
        .zeraE               ( zeraE               ),
        .contaE              ( contaE              ),
        .zeraR               ( zeraR               ),
        .contaR              ( contaR              ),
        .zeraT               ( zeraT               ),
        .contaT              ( contaT              ),
        .registraJ           ( registraJ           ),
        .ativa_leds          ( ativa_leds          ),
        .fimNota             ( fimNota             ),
        .fimPausa            ( fimPausa            ),
        .enderecoIgualRodada ( enderecoIgualRodada ),
        .fim_musica          ( fim_musica          ),
        .nota_feita          ( nota_feita          ),
        .fimTempo            ( fimTempo            ),
        .nota_correta        ( nota_correta        ),
        .tempo_correto       ( tempo_correto       ),
        .leds                ( leds                ),
        .pulso_buzzer        ( pulso_buzzer        ),
        .db_nota             ( s_db_nota           ),
        .db_rodada           ( s_db_rodada         )
    );

    unidade_controle unidade_controle (
        .clock               ( clock               ),
        .rst                 ( rst                 ),
        .iniciar             ( iniciar             ),
        .tentar_dnv          ( tentar_dnv          ),
        .fimNota             ( fimNota             ),
        .fimPausa            ( fimPausa            ),
        .enderecoIgualRodada ( enderecoIgualRodada ),
        .fim_musica          ( fim_musica          ),
        .nota_feita          ( nota_feita          ),
        .fimTempo            ( fimTempo            ),
        .nota_correta        ( nota_correta        ),
        .tempo_correto       ( tempo_correto       ),
        .zeraE               ( zeraE               ),
        .contaE              ( contaE              ),
        .zeraR               ( zeraR               ),
        .contaR              ( contaR              ),
        .zeraT               ( zeraT               ),
        .contaT              ( contaT              ),
        .registraJ           ( registraJ           ),
        .ativa_leds          ( ativa_leds          ),
        .ganhou              ( ganhou              ),
        .perdeu              ( perdeu              ),
        .vez_jogador         ( vez_jogador         )
    );

    // Last pressed pitch
    hexa7seg display_nota (
        .hexa    ( s_db_nota ),
        .display ( db_nota   )
    );

    hexa7seg display_rodada (
        .hexa    ( s_db_rodada ),
        .display ( db_rodada   )
    );

endmodule

/* verilog/fluxo_dados.sv */
`timescale 1ns/1ns

module fluxo_dados #(
    parameter int CLOCK_FREQ = 50000000
) (
    input  logic                      clock,
    input  logic                      rst,
    input  music_game_pkg::nota_t     botoes_encoded,
    input  logic                      zeraE,
    input  logic                      contaE,
    input  logic                      zeraR,
    input  logic                      contaR,
    input  logic                      zeraT,
    input  logic                      contaT,
    input  logic                      registraJ,
    input  logic                      ativa_leds,
    output logic                      fimNota,
    output logic                      fimPausa,
    output logic                      enderecoIgualRodada,
    output logic                      fim_musica,
    output logic                      nota_feita,
    output logic                      fimTempo,
    output logic                      nota_correta,
    output logic                      tempo_correto,
    output music_game_pkg::leds_t     leds,
    output logic                      pulso_buzzer,
    output music_game_pkg::nota_t     db_nota,
    output music_game_pkg::endereco_t db_rodada
);
    import music_game_pkg::*;

    // 120 BPM
    localparam int CICLOS_BATIDA = CLOCK_FREQ / 2;
    localparam int MEIA_BATIDA   = CICLOS_BATIDA / 2;
    localparam int LARG_CICLO    = $clog2(CICLOS_BATIDA + 1);
    // Hold count after the first pressed cycle, already half a beat ahead
    localparam int INICIO_CICLO  = (MEIA_BATIDA + 1) % CICLOS_BATIDA;
    localparam int INICIO_BATIDA = (MEIA_BATIDA + 1) / CICLOS_BATIDA;

    endereco_t             endereco;
    endereco_t             rodada;
    nota_t                 nota_mem;
    nota_t                 nota_jogada;
    tempo_t                tempo_mem;
    tempo_t                batidas_press;
    logic [LARG_CICLO-1:0] ciclo;
    logic [LARG_CICLO-1:0] ciclo_press;
    logic [3:0]            batidas;
    logic                  fim_batida;
    logic [1:0]            cont_buzzer;
    logic                  buzzer;

    song_memory memoria (
        .endereco ( endereco  ),
        .nota     ( nota_mem  ),
        .tempo    ( tempo_mem )
    );

    always_ff @(posedge clock) begin
        if (rst || zeraE) begin
            endereco <= '0;
        end else if (contaE) begin
            endereco <= endereco + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || zeraR) begin
            rodada <= '0;
        end else if (contaR) begin
            rodada <= rodada + 1'b1;
        end
    end

    // Beat timer
    always_ff @(posedge clock) begin
        if (rst || zeraT) begin
            ciclo   <= '0;
            batidas <= '0;
        end else if (contaT) begin
            if (fim_batida) begin
                ciclo   <= '0;
                batidas <= batidas + 1'b1;
            end else begin
                ciclo <= ciclo + 1'b1;
            end
        end
    end

    assign fim_batida = (ciclo == LARG_CICLO'(CICLOS_BATIDA - 1));

    // Each fires on the last cycle of its span
    assign fimNota  = fim_batida && (batidas == {1'b0, tempo_mem - 1'b1});
    assign fimPausa = fim_batida && (batidas == 4'(GAP_BEATS - 1));
    assign fimTempo = fim_batida && (batidas == 4'(TIMEOUT_BEATS - 1));

    assign enderecoIgualRodada = (endereco == rodada);
    assign fim_musica          = (rodada == endereco_t'(NUM_NOTAS - 1));
    assign nota_feita          = (botoes_encoded != '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            nota_jogada <= '0;
        end else if (registraJ) begin
            nota_jogada <= botoes_encoded;
        end
    end

    // Hold time in beats, rounded to nearest; stops at 7
    always_ff @(posedge clock) begin
        if (registraJ) begin
            ciclo_press   <= LARG_CICLO'(INICIO_CICLO);
            batidas_press <= tempo_t'(INICIO_BATIDA);
        end else if (nota_feita && batidas_press != '1) begin
            if (ciclo_press == LARG_CICLO'(CICLOS_BATIDA - 1)) begin
                ciclo_press   <= '0;
                batidas_press <= batidas_press + 1'b1;
            end else begin
                ciclo_press <= ciclo_press + 1'b1;
            end
        end
    end

    assign nota_correta  = (nota_jogada == nota_mem);
    assign tempo_correto = (batidas_press == tempo_mem);

    always_comb begin
        leds = '0;
        if (ativa_leds && nota_mem != '0) begin
            leds = leds_t'(1) << (nota_mem - 1'b1);
        end
    end

    // Square wave, toggles every 4 cycles
    always_ff @(posedge clock) begin
        if (rst || !ativa_leds) begin
            cont_buzzer <= '0;
            buzzer      <= 1'b0;
        end else begin
            cont_buzzer <= cont_buzzer + 1'b1;
            if (cont_buzzer == 2'd3) begin
                buzzer <= ~buzzer;
            end
        end
    end

    assign pulso_buzzer = buzzer && ativa_leds;

    assign db_nota   = nota_jogada;
    assign db_rodada = rodada;

endmodule

/* verilog/hexa7seg.sv */
`timescale 1ns/1ns

// Segment order gfedcba, active low
module hexa7seg (
    input  logic [3:0] hexa,
    output logic [6:0] display
);

    always_comb begin
        case (hexa)
            4'h0:    display = 7'b1000000;
            4'h1:    display = 7'b1111001;
            4'h2:    display = 7'b0100100;
            4'h3:    display = 7'b0110000;
            4'h4:    display = 7'b0011001;
            4'h5:    display = 7'b0010010;
            4'h6:    display = 7'b0000010;
            4'h7:    display = 7'b1111000;
            4'h8:    display = 7'b0000000;
            4'h9:    display = 7'b0010000;
            4'hA:    display = 7'b0001000;
            4'hB:    display = 7'b0000011;
            4'hC:    display = 7'b1000110;
            4'hD:    display = 7'b0100001;
            4'hE:    display = 7'b0000110;
            4'hF:    display = 7'b0001110;
            default: display = 7'b1111111;
        endcase
    end

endmodule

/* verilog/music_game_pkg.sv */
package music_game_pkg;

    typedef logic [3:0]  nota_t;
    typedef logic [2:0]  tempo_t;
    typedef logic [3:0]  endereco_t;
    typedef logic [11:0] leds_t;

    localparam int NUM_NOTAS = 6;

    // Pitch 1 to 12, one entry per note
    localparam nota_t SONG_NOTAS [NUM_NOTAS] = '{
        4'd5, 4'd5, 4'd7, 4'd5, 4'd10, 4'd9
    };

    // Length in beats
    localparam tempo_t SONG_TEMPOS [NUM_NOTAS] = '{
        3'd1, 3'd1, 3'd2, 3'd2, 3'd2, 3'd4
    };

    localparam int TIMEOUT_BEATS = 8;
    localparam int GAP_BEATS     = 1;

    typedef enum logic [3:0] {
        inicial,
        prepara,
        toca_nota,
        pausa,
        proxima_toca,
        espera_jogada,
        mede_jogada,
        compara,
        proxima_jogada,
        proxima_rodada,
        fim_ganhou,
        fim_perdeu
    } estado_t;

endpackage

/* verilog/song_memory.sv */
`timescale 1ns/1ns

module song_memory (
    input  music_game_pkg::endereco_t endereco,
    output music_game_pkg::nota_t     nota,
    output music_game_pkg::tempo_t    tempo
);
    import music_game_pkg::*;

    always_comb begin
        case (endereco)
            4'd0: begin
                nota  = SONG_NOTAS[0];
                tempo = SONG_TEMPOS[0];
            end
            4'd1: begin
                nota  = SONG_NOTAS[1];
                tempo = SONG_TEMPOS[1];
            end
            4'd2: begin
                nota  = SONG_NOTAS[2];
                tempo = SONG_TEMPOS[2];
            end
            4'd3: begin
                nota  = SONG_NOTAS[3];
                tempo = SONG_TEMPOS[3];
            end
            4'd4: begin
                nota  = SONG_NOTAS[4];
                tempo = SONG_TEMPOS[4];
            end
            4'd5: begin
                nota  = SONG_NOTAS[5];
                tempo = SONG_TEMPOS[5];
            end
            // Past the end of the song
            default: begin
                nota  = '0;
                tempo = '0;
            end
        endcase
    end

endmodule

/* verilog/unidade_controle.sv */
`timescale 1ns/1ns

module unidade_controle (
    input  logic clock,
    input  logic rst,
    input  logic iniciar,
    input  logic tentar_dnv,
    input  logic fimNota,
    input  logic fimPausa,
    input  logic enderecoIgualRodada,
    input  logic fim_musica,
    input  logic nota_feita,
    input  logic fimTempo,
    input  logic nota_correta,
    input  logic tempo_correto,
    output logic zeraE,
    output logic contaE,
    output logic zeraR,
    output logic contaR,
    output logic zeraT,
    output logic contaT,
    output logic registraJ,
    output logic ativa_leds,
    output logic ganhou,
    output logic perdeu,
    output logic vez_jogador
);
    import music_game_pkg::*;

    estado_t estado;
    estado_t proximo;

    always_ff @(posedge clock) begin
        if (rst) begin
            estado <= inicial;
        end else begin
            estado <= proximo;
        end
    end

    always_comb begin
        proximo     = estado;
        zeraE       = 1'b0;
        contaE      = 1'b0;
        zeraR       = 1'b0;
        contaR      = 1'b0;
        zeraT       = 1'b0;
        contaT      = 1'b0;
        registraJ   = 1'b0;
        ativa_leds  = 1'b0;
        ganhou      = 1'b0;
        perdeu      = 1'b0;
        vez_jogador = 1'b0;

        case (estado)
            inicial: begin
                if (iniciar) begin
                    zeraR   = 1'b1;
                    proximo = prepara;
                end
            end
            prepara: begin
                zeraE   = 1'b1;
                zeraT   = 1'b1;
                proximo = toca_nota;
            end
            toca_nota: begin
                ativa_leds = 1'b1;
                contaT     = 1'b1;
                if (fimNota) begin
                    zeraT   = 1'b1;
                    proximo = enderecoIgualRodada ? pausa : proxima_toca;
                end
            end
            // Gap before the next played note
            proxima_toca: begin
                contaT = 1'b1;
                if (fimPausa) begin
                    zeraT   = 1'b1;
                    contaE  = 1'b1;
                    proximo = toca_nota;
                end
            end
            // Gap after the last played note, then the player's turn
            pausa: begin
                contaT = 1'b1;
                if (fimPausa) begin
                    zeraT   = 1'b1;
                    zeraE   = 1'b1;
                    proximo = espera_jogada;
                end
            end
            espera_jogada: begin
                vez_jogador = 1'b1;
                contaT      = 1'b1;
                if (nota_feita) begin
                    registraJ = 1'b1;
                    proximo   = mede_jogada;
                end else if (fimTempo) begin
                    proximo = fim_perdeu;
                end
            end
            mede_jogada: begin
                vez_jogador = 1'b1;
                if (!nota_feita) begin
                    proximo = compara;
                end
            end
            compara: begin
                vez_jogador = 1'b1;
                if (!(nota_correta && tempo_correto)) begin
                    proximo = fim_perdeu;
                end else if (!enderecoIgualRodada) begin
                    proximo = proxima_jogada;
                end else if (fim_musica) begin
                    proximo = fim_ganhou;
                end else begin
                    contaR  = 1'b1;
                    zeraE   = 1'b1;
                    zeraT   = 1'b1;
                    proximo = proxima_rodada;
                end
            end
            proxima_jogada: begin
                vez_jogador = 1'b1;
                contaE      = 1'b1;
                zeraT       = 1'b1;
                proximo     = espera_jogada;
            end
            // One silent beat before the next round
            proxima_rodada: begin
                contaT = 1'b1;
                if (fimPausa) begin
                    zeraT   = 1'b1;
                    proximo = toca_nota;
                end
            end
            fim_ganhou: begin
                ganhou = 1'b1;
                if (iniciar) begin
                    zeraR   = 1'b1;
                    proximo = prepara;
                end
            end
            fim_perdeu: begin
                perdeu = 1'b1;
                if (iniciar) begin
                    zeraR   = 1'b1;
                    proximo = prepara;
                end else if (tentar_dnv) begin
                    proximo = prepara;
                end
            end
            default: proximo = inicial;
        endcase
    end

endmodule

/* vlog.f */
verilog/music_game_pkg.sv
verilog/song_memory.sv
verilog/hexa7seg.sv
verilog/fluxo_dados.sv
verilog/unidade_controle.sv
verilog/circuito_principal.sv
verification/circuito_principal_chk.sv
verification/circuito_principal_tb.sv
